// File: design/mulTypesPkg.sv
package mulTypesPkg;

	// one full register operand
	typedef logic [63:0] operandT;

	// 16-bit slice of the low word of an operand
	typedef logic [15:0] halfT;

	// product of two extended halves
	// kept to 32 bits, enough for any signed or unsigned pair
	typedef logic [31:0] partialT;

	// upper and lower words of a result
	typedef struct packed {
		logic [31:0] hi;
		logic [31:0] lo;
	} halvesT;

	// one result word seen two ways
	// full for the 64-bit product, halves when the top is refilled
	typedef union packed {
		operandT full;
		halvesT halves;
	} resultU;

	// unheld edges from operand capture to result
	localparam int stageCountP = 2;

endpackage

// File: design/mulCmdPkg.sv
package mulCmdPkg;

	// width of the command extension word
	localparam int cmdWidthP = 9;

	// command extension word as sampled with the operands
	typedef logic [cmdWidthP-1:0] cmdT;

	// both operands unsigned when set
	localparam int unsignedBitP = 0;

	// full 64-bit product when set
	// otherwise low 32 bits extended to 64
	localparam int wideBitP = 2;

	// bits 1 and 3 to 8 reserved

endpackage

// File: design/mulStageIf.sv
`timescale 1ns/100ps

interface mulStageIf;

	// partial products of the low words
	// aa is lo*lo, ab is rs lo * rt hi, ba is rs hi * rt lo, bb is hi*hi
	mulTypesPkg::partialT aa;
	mulTypesPkg::partialT ab;
	mulTypesPkg::partialT ba;
	mulTypesPkg::partialT bb;

	// mode bits riding along with the products
	logic isUnsigned;
	logic isWide;

	modport producer
	(
		output aa,
		output ab,
		output ba,
		output bb,
		output isUnsigned,
		output isWide
	);

	modport consumer
	(
		input aa,
		input ab,
		input ba,
		input bb,
		input isUnsigned,
		input isWide
	);

endinterface

// File: design/csAdd64.sv
`timescale 1ns/100ps

module csAdd64
(
	input mulTypesPkg::operandT a,
	input mulTypesPkg::operandT b,
	output mulTypesPkg::operandT sum
);

	// carry into each 16-bit block
	logic [3:0] carry;

	// candidate sums for carry in of zero and one
	logic [16:0] sumZero [4];
	logic [16:0] sumOne [4];

	// lowest block never sees a carry
	assign carry[0] = 1'b0;

	for (genvar i = 0; i < 4; i++)
	begin : gBlock
		logic [16:0] aExt;
		logic [16:0] bExt;

		assign aExt = {1'b0, a[16*i +: 16]};
		assign bExt = {1'b0, b[16*i +: 16]};

		// both candidates settle in parallel
		assign sumZero[i] = aExt + bExt;
		assign sumOne[i] = aExt + bExt + 17'd1;

		// real carry only selects
		assign sum[16*i +: 16] = carry[i] ? sumOne[i][15:0] : sumZero[i][15:0];

		if (i < 3)
		begin : gCarry
			assign carry[i+1] = carry[i] ? sumOne[i][16] : sumZero[i][16];
		end
	end

endmodule

// File: design/mulPartials.sv
`timescale 1ns/100ps

module mulPartials
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input mulTypesPkg::operandT rs,
	input mulTypesPkg::operandT rt,
	input mulCmdPkg::cmdT cmd,
	mulStageIf.producer stage
);

	logic isUnsigned;
	logic isWide;

	mulTypesPkg::halfT rsLo;
	mulTypesPkg::halfT rsHi;
	mulTypesPkg::halfT rtLo;
	mulTypesPkg::halfT rtHi;

	// sign fill above the upper halves
	mulTypesPkg::halfT rsFill;
	mulTypesPkg::halfT rtFill;

	mulTypesPkg::partialT prodAA;
	mulTypesPkg::partialT prodAB;
	mulTypesPkg::partialT prodBA;
	mulTypesPkg::partialT prodBB;

	assign isUnsigned = cmd[mulCmdPkg::unsignedBitP];
	assign isWide = cmd[mulCmdPkg::wideBitP];

	// upper 32 bits of each operand play no part
	assign rsLo = rs[15:0];
	assign rsHi = rs[31:16];
	assign rtLo = rt[15:0];
	assign rtHi = rt[31:16];

	assign rsFill = (rsHi[15] && !isUnsigned) ? '1 : '0;
	assign rtFill = (rtHi[15] && !isUnsigned) ? '1 : '0;

	// low halves always zero-extended
	assign prodAA = {16'h0000, rsLo} * {16'h0000, rtLo};
	assign prodAB = {16'h0000, rsLo} * {rtFill, rtHi};
	assign prodBA = {rsFill, rsHi} * {16'h0000, rtLo};

	// signed hi*hi stays within 32 bits
	assign prodBB = {rsFill, rsHi} * {rtFill, rtHi};

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			stage.aa <= '0;
			stage.ab <= '0;
			stage.ba <= '0;
			stage.bb <= '0;
			stage.isUnsigned <= 1'b0;
			stage.isWide <= 1'b0;
		end
		else if (!hold)
		begin
			stage.aa <= prodAA;
			stage.ab <= prodAB;
			stage.ba <= prodBA;
			stage.bb <= prodBB;
			stage.isUnsigned <= isUnsigned;
			stage.isWide <= isWide;
		end
	end

	// held edge leaves stage one frozen
	holdFreezesStage: assert property (
		@(posedge clock) disable iff (!rstN)
		hold |=> $stable({stage.aa, stage.ab, stage.ba, stage.bb,
			stage.isUnsigned, stage.isWide})
	);

endmodule

// File: design/mulCombine.sv
`timescale 1ns/100ps

module mulCombine
(
	input logic clock,
	input logic rstN,
	input logic hold,
	mulStageIf.consumer stage,
	output mulTypesPkg::operandT result
);

	// sign fill above each cross product
	logic [15:0] abFill;
	logic [15:0] baFill;

	mulTypesPkg::operandT crossAB;
	mulTypesPkg::operandT crossBA;
	mulTypesPkg::operandT crossSum;

	// stage two registers
	mulTypesPkg::operandT outerWord;
	mulTypesPkg::operandT crossWord;
	logic isUnsignedQ;
	logic isWideQ;

	mulTypesPkg::operandT fullSum;
	mulTypesPkg::resultU shaped;

	assign abFill = (stage.ab[31] && !stage.isUnsigned) ? '1 : '0;
	assign baFill = (stage.ba[31] && !stage.isUnsigned) ? '1 : '0;

	// cross products sit 16 bits up
	assign crossAB = {abFill, stage.ab, 16'h0000};
	assign crossBA = {baFill, stage.ba, 16'h0000};

	csAdd64 uCrossAdd
	(
		.a(crossAB),
		.b(crossBA),
		.sum(crossSum)
	);

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			outerWord <= '0;
			crossWord <= '0;
			isUnsignedQ <= 1'b0;
			isWideQ <= 1'b0;
		end
		else if (!hold)
		begin
			// hi*hi over lo*lo never overlap
			outerWord <= {stage.bb, stage.aa};
			crossWord <= crossSum;
			isUnsignedQ <= stage.isUnsigned;
			isWideQ <= stage.isWide;
		end
	end

	csAdd64 uFinalAdd
	(
		.a(outerWord),
		.b(crossWord),
		.sum(fullSum)
	);

	always_comb
	begin
		shaped.full = fullSum;
		// narrow mode refills the upper word from bit 31
		if (!isWideQ)
		begin
			shaped.halves.hi = (shaped.halves.lo[31] && !isUnsignedQ) ? '1 : '0;
		end
	end

	assign result = shaped.full;

	// both stages hold known data once reset has been gone long enough
	resultKnown: assert property (
		@(posedge clock) disable iff (!rstN)
		$past(rstN, mulTypesPkg::stageCountP) |-> !$isunknown(result)
	);

endmodule

// File: design/mulTop.sv
`timescale 1ns/100ps

module mulTop
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input mulTypesPkg::operandT rs,
	input mulTypesPkg::operandT rt,
	input mulCmdPkg::cmdT cmd,
	output mulTypesPkg::operandT result
);

	// partial products between the stages
	mulStageIf stageBus ();

	mulPartials uPartials
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.rs(rs),
		.rt(rt),
		.cmd(cmd),
		.stage(stageBus.producer)
	);

	// second stage drives result combinationally
	mulCombine uCombine
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.stage(stageBus.consumer),
		.result(result)
	);

endmodule

// File: verification/mulTests.svh
task automatic resetState();
	mulTypesPkg::resultU zero;
	int i;
	zero.full = '0;
	startTest();
	rstN = 1'b0;
	#1;
	compareResult("resetState", zero, sampleResult());
	// two edges in reset
	for (i = 0; i < 2; i++)
	begin
		nextDrivePoint();
		compareResult("resetState", zero, sampleResult());
	end
	rstN = 1'b1;
	for (i = 0; i < 2; i++)
	begin
		nextDrivePoint();
		compareResult("resetState", zero, sampleResult());
	end
	finishTest("resetState");
endtask

task automatic signedWide();
	mulCmdPkg::cmdT c;
	c = makeCmd(1'b0, 1'b1);
	startTest();
	// both negative
	checkOp("signedWide", 64'hFFFF_FFFF_FFFF_FFFD, 64'hFFFF_FFFF_FFFF_FFF9, c);
	checkOp("signedWide", 64'h0000_0000_8765_4321, 64'h0000_0000_F00D_0001, c);
	// mixed signs
	checkOp("signedWide", 64'h0000_0000_FFFE_1DC0, 64'h0000_0000_0000_0315, c);
	checkOp("signedWide", 64'h0000_0000_7FFF_FFFF, 64'h0000_0000_8000_0001, c);
	// most negative squared
	checkOp("signedWide", 64'h0000_0000_8000_0000, 64'h0000_0000_8000_0000, c);
	checkOp("signedWide", 64'h0000_0000_0000_0000, 64'h0000_0000_1234_5678, c);
	checkOp("signedWide", 64'h0000_0000_8765_4321, 64'h0000_0000_0000_0000, c);
	// upper words must not matter
	checkOp("signedWide", 64'hDEAD_BEEF_0000_0005, 64'h1234_5678_FFFF_FFFE, c);
	checkOp("signedWide", 64'hFFFF_FFFF_0000_0003, 64'h8000_0000_0000_0004, c);
	finishTest("signedWide");
endtask

task automatic unsignedWide();
	mulCmdPkg::cmdT c;
	int i;
	c = makeCmd(1'b1, 1'b1);
	startTest();
	checkOp("unsignedWide", 64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, c);
	checkOp("unsignedWide", 64'h0000_0000_FFFF_FFFF, 64'h0000_0000_0000_0001, c);
	checkOp("unsignedWide", 64'hA5A5_0000_8000_0000, 64'h0000_0000_0000_0002, c);
	for (i = 0; i < 200; i++)
		checkOp("unsignedWide", {$urandom, $urandom}, {$urandom, $urandom}, c);
	finishTest("unsignedWide");
endtask

task automatic narrowExtend();
	mulCmdPkg::cmdT signedNarrow;
	mulCmdPkg::cmdT unsignedNarrow;
	signedNarrow = makeCmd(1'b0, 1'b0);
	unsignedNarrow = makeCmd(1'b1, 1'b0);
	startTest();
	// low word with bit 31 set, signed then unsigned
	checkOp("narrowExtend", 64'h0000_0000_0000_8000, 64'h0000_0000_0001_0000, signedNarrow);
	checkOp("narrowExtend", 64'h0000_0000_0000_8000, 64'h0000_0000_0001_0000, unsignedNarrow);
	checkOp("narrowExtend", 64'h0000_0000_FFFF_FFFF, 64'h0000_0000_0000_0005, signedNarrow);
	checkOp("narrowExtend", 64'h0000_0000_FFFF_FFFF, 64'h0000_0000_0000_0005, unsignedNarrow);
	// bit 31 clear
	checkOp("narrowExtend", 64'hFFFF_0000_0000_0003, 64'h0000_1111_0000_0007, signedNarrow);
	checkOp("narrowExtend", 64'h0000_0000_0001_0000, 64'h0000_0000_0001_0000, signedNarrow);
	checkOp("narrowExtend", 64'h0000_0000_FFFF_FFFF, 64'h0000_0000_FFFF_FFFF, signedNarrow);
	finishTest("narrowExtend");
endtask

task automatic backToBack();
	localparam int countP = 12;
	mulTypesPkg::resultU expectQ[$];
	mulTypesPkg::operandT a;
	mulTypesPkg::operandT b;
	mulCmdPkg::cmdT c;
	int i;
	startTest();
	hold = 1'b0;
	// a new operation every edge, results trail by stageCountP - 1 edges
	for (i = 0; i < countP + mulTypesPkg::stageCountP - 1; i++)
	begin
		if (i < countP)
		begin
			a = {$urandom, $urandom};
			b = {$urandom, $urandom};
			c = mulCmdPkg::cmdT'($urandom);
			rs = a;
			rt = b;
			cmd = c;
			expectQ.push_back(modelProduct(a, b, c));
		end
		nextDrivePoint();
		if (i >= mulTypesPkg::stageCountP - 1)
			compareResult("backToBack", expectQ.pop_front(), sampleResult());
	end
	finishTest("backToBack");
endtask

task automatic holdStall();
	mulTypesPkg::operandT aFirst;
	mulTypesPkg::operandT bFirst;
	mulTypesPkg::operandT aNext;
	mulTypesPkg::operandT bNext;
	mulCmdPkg::cmdT cFirst;
	mulCmdPkg::cmdT cNext;
	mulTypesPkg::resultU frozen;
	int stallCycles;
	int i;
	bit arrived;
	startTest();
	aFirst = {$urandom, $urandom};
	bFirst = {$urandom, $urandom};
	aNext = {$urandom, $urandom};
	bNext = {$urandom, $urandom};
	cFirst = makeCmd(1'b0, 1'b1);
	cNext = makeCmd(1'b1, 1'b0);
	stallCycles = $urandom_range(6, 1);
	rs = aFirst;
	rt = bFirst;
	cmd = cFirst;
	hold = 1'b0;
	awaitUnheld(1, arrived);
	// next operation sits on the inputs during the stall
	rs = aNext;
	rt = bNext;
	cmd = cNext;
	hold = 1'b1;
	frozen = sampleResult();
	for (i = 0; i < stallCycles; i++)
	begin
		nextDrivePoint();
		compareResult("holdStall", frozen, sampleResult());
	end
	hold = 1'b0;
	if (arrived)
		awaitUnheld(1, arrived);
	if (arrived)
		compareResult("holdStall", modelProduct(aFirst, bFirst, cFirst), sampleResult());
	if (arrived)
		awaitUnheld(1, arrived);
	if (arrived)
		compareResult("holdStall", modelProduct(aNext, bNext, cNext), sampleResult());
	else
		missingResult("holdStall");
	finishTest("holdStall");
endtask

// File: verification/mulTb.sv
`timescale 1ns/100ps

module mulTb;

	localparam int seedP = 34082;
	localparam int timeoutCyclesP = 20;
	localparam time driveDelayP = 10;

	logic clock;
	logic rstN;
	logic hold;
	mulTypesPkg::operandT rs;
	mulTypesPkg::operandT rt;
	mulCmdPkg::cmdT cmd;
	mulTypesPkg::operandT result;

	int testCount;
	int failedCount;
	int errorCount;
	int testErrors;

	mulTop u_dut
	(
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.rs(rs),
		.rt(rt),
		.cmd(cmd),
		.result(result)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic nextDrivePoint();
		@(posedge clock);
		#driveDelayP;
	endtask

	// count edges that see hold low, give up after the timeout
	task automatic awaitUnheld(input int needed, output bit arrived);
		int unheld;
		int cycles;
		unheld = 0;
		cycles = 0;
		while (unheld < needed && cycles < timeoutCyclesP)
		begin
			// hold as the coming edge will see it
			if (!hold)
				unheld++;
			nextDrivePoint();
			cycles++;
		end
		arrived = (unheld >= needed);
	endtask

	function automatic mulTypesPkg::resultU sampleResult();
		mulTypesPkg::resultU r;
		r.full = result;
		return r;
	endfunction

	// 32x32 product of the low words, then width and extension
	function automatic mulTypesPkg::resultU modelProduct(input mulTypesPkg::operandT a,
		input mulTypesPkg::operandT b, input mulCmdPkg::cmdT c);
		mulTypesPkg::resultU r;
		longint signedA;
		longint signedB;
		logic [63:0] zeroA;
		logic [63:0] zeroB;
		signedA = longint'($signed(a[31:0]));
		signedB = longint'($signed(b[31:0]));
		zeroA = {32'h0, a[31:0]};
		zeroB = {32'h0, b[31:0]};
		if (c[mulCmdPkg::unsignedBitP])
			r.full = zeroA * zeroB;
		else
			r.full = signedA * signedB;
		if (!c[mulCmdPkg::wideBitP])
			r.halves.hi = c[mulCmdPkg::unsignedBitP] ? 32'h0 : {32{r.halves.lo[31]}};
		return r;
	endfunction

	function automatic mulCmdPkg::cmdT makeCmd(input bit isUnsigned, input bit isWide);
		mulCmdPkg::cmdT c;
		c = '0;
		c[mulCmdPkg::unsignedBitP] = isUnsigned;
		c[mulCmdPkg::wideBitP] = isWide;
		return c;
	endfunction

	task automatic compareResult(input string testName, input mulTypesPkg::resultU expected,
		input mulTypesPkg::resultU actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %h, actual %h", testName, expected.full, actual.full);
			testErrors++;
		end
	endtask

	task automatic missingResult(input string testName);
		$display("%s: the result did not arrive within %0d cycles", testName, timeoutCyclesP);
		testErrors++;
	endtask

	task automatic startTest();
		testErrors = 0;
	endtask

	task automatic finishTest(input string testName);
		testCount++;
		errorCount += testErrors;
		if (testErrors == 0)
			$display("%s: ok", testName);
		else
		begin
			failedCount++;
			$display("%s: %0d errors", testName, testErrors);
		end
	endtask

	// one operation on its own, checked after its second unheld edge
	task automatic checkOp(input string testName, input mulTypesPkg::operandT a,
		input mulTypesPkg::operandT b, input mulCmdPkg::cmdT c);
		bit arrived;
		rs = a;
		rt = b;
		cmd = c;
		hold = 1'b0;
		awaitUnheld(mulTypesPkg::stageCountP, arrived);
		if (arrived)
			compareResult(testName, modelProduct(a, b, c), sampleResult());
		else
			missingResult(testName);
	endtask

	`include "mulTests.svh"

	initial
	begin
		void'($urandom(seedP));
		rstN = 1'b1;
		hold = 1'b0;
		rs = '0;
		rt = '0;
		cmd = '0;
		testCount = 0;
		failedCount = 0;
		errorCount = 0;
		testErrors = 0;
		#driveDelayP;
		resetState();
		signedWide();
		unsignedWide();
		narrowExtend();
		backToBack();
		holdStall();
		$display("tests run %0d, tests with errors %0d, errors %0d",
			testCount, failedCount, errorCount);
		if (failedCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: build.f
+incdir+verification
design/mulTypesPkg.sv
design/mulCmdPkg.sv
design/mulStageIf.sv
design/csAdd64.sv
design/mulPartials.sv
design/mulCombine.sv
design/mulTop.sv
verification/mulTb.sv

// File: Bender.yml
package:
  name: mul_unit

sources:
  - files:
      - design/mulTypesPkg.sv
      - design/mulCmdPkg.sv
      - design/mulStageIf.sv
      - design/csAdd64.sv
      - design/mulPartials.sv
      - design/mulCombine.sv
      - design/mulTop.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/mulTb.sv
